//--- logic/cpuPkg.sv
package cpuPkg;

  localparam int xlen = 32;
  localparam int regIndexW = 5;
  localparam int imemDepth = 64;
  localparam int dmemDepth = 64;

  // RV32I major opcodes for the supported subset
  typedef enum logic [6:0] {
    opReg   = 7'b0110011,
    opImm   = 7'b0010011,
    opLoad  = 7'b0000011,
    opStore = 7'b0100011
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt
  } aluOpT;

  // Operand source picked by the forwarding units
  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdWb   = 2'b01,
    fwdMem  = 2'b10
  } fwdSelT;

  typedef struct packed {
    logic [xlen-1:0]      rs1Data;
    logic [xlen-1:0]      rs2Data;
    logic [regIndexW-1:0] rs1Index;
    logic [regIndexW-1:0] rs2Index;
    logic [regIndexW-1:0] rdIndex;
    logic [xlen-1:0]      imm;
    aluOpT                aluOp;
    logic                 aluSrc;
    logic                 memRead;
    logic                 memWrite;
    logic                 memToReg;
    logic                 regWrite;
  } idExT;

  typedef struct packed {
    logic [xlen-1:0]      aluResult;
    logic [xlen-1:0]      storeData;
    logic [regIndexW-1:0] rdIndex;
    logic                 memRead;
    logic                 memWrite;
    logic                 memToReg;
    logic                 regWrite;
  } exMemT;

  typedef struct packed {
    logic [xlen-1:0]      loadData;
    logic [xlen-1:0]      execData;
    logic [regIndexW-1:0] rdIndex;
    logic                 memToReg;
    logic                 regWrite;
  } memWbT;

endpackage

//--- logic/instructionFetch.sv
`timescale 1ns/1ps

module instructionFetch (
  input  logic                                  clk,
  input  logic                                  arstN,
  input  logic                                  run,
  input  logic                                  stall,
  input  logic                                  progWrite,
  input  logic [$clog2(cpuPkg::imemDepth)-1:0]  progAddr,
  input  logic [cpuPkg::xlen-1:0]               progData,
  output logic [cpuPkg::xlen-1:0]               instr,
  output logic                                  instrValid
);

  logic [cpuPkg::xlen-1:0] imem [cpuPkg::imemDepth];
  logic [cpuPkg::xlen-1:0] pc;
  logic [cpuPkg::xlen-1:0] fetched;

  // Word address from pc[7:2]
  assign fetched = imem[pc[$clog2(cpuPkg::imemDepth)+1:2]];

  always_ff @(posedge clk) begin
    if (progWrite) begin
      imem[progAddr] <= progData;
    end
  end

  // Fetch/decode barrier
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc         <= '0;
      instr      <= '0;
      instrValid <= 1'b0;
    end else if (!stall) begin
      if (run) begin
        pc         <= pc + cpuPkg::xlen'(4);
        instr      <= fetched;
        instrValid <= 1'b1;
      end else begin
        // Frozen, decode sees bubbles
        instrValid <= 1'b0;
      end
    end
  end

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [cpuPkg::regIndexW-1:0]  rs1Index,
  input  logic [cpuPkg::regIndexW-1:0]  rs2Index,
  input  logic [cpuPkg::regIndexW-1:0]  writeIndex,
  input  logic [cpuPkg::xlen-1:0]       writeData,
  input  logic                          writeEnable,
  output logic [cpuPkg::xlen-1:0]       rs1Data,
  output logic [cpuPkg::xlen-1:0]       rs2Data
);

  // x0 has no storage
  logic [cpuPkg::xlen-1:0] regs [1:31];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && writeIndex != '0) begin
      regs[writeIndex] <= writeData;
    end
  end

  // Same-cycle write passes straight through to the read ports
  assign rs1Data = (rs1Index == '0) ? '0 :
                   (writeEnable && writeIndex == rs1Index) ? writeData : regs[rs1Index];
  assign rs2Data = (rs2Index == '0) ? '0 :
                   (writeEnable && writeIndex == rs2Index) ? writeData : regs[rs2Index];

endmodule

//--- logic/decodeControl.sv
`timescale 1ns/1ps

module decodeControl (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [cpuPkg::xlen-1:0]       instr,
  input  logic                          instrValid,
  output logic [cpuPkg::regIndexW-1:0]  rs1Index,
  output logic [cpuPkg::regIndexW-1:0]  rs2Index,
  input  logic [cpuPkg::xlen-1:0]       rs1Data,
  input  logic [cpuPkg::xlen-1:0]       rs2Data,
  output logic                          stall,
  output cpuPkg::idExT                  idEx
);

  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [cpuPkg::xlen-1:0] immI;
  logic [cpuPkg::xlen-1:0] immS;
  cpuPkg::aluOpT           aluOp;
  logic                    aluSrc;
  logic                    memRead;
  logic                    memWrite;
  logic                    memToReg;
  logic                    regWrite;
  cpuPkg::idExT            idExNext;

  assign rs1Index = instr[19:15];
  assign rs2Index = instr[24:20];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign immI     = {{20{instr[31]}}, instr[31:20]};
  assign immS     = {{20{instr[31]}}, instr[31:25], instr[11:7]};

  // Unknown encodings fall through with every control bit low
  always_comb begin
    aluOp    = cpuPkg::aluAdd;
    aluSrc   = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    case (instr[6:0])
      cpuPkg::opReg: begin
        regWrite = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: aluOp = cpuPkg::aluAdd;
          {7'b0100000, 3'b000}: aluOp = cpuPkg::aluSub;
          {7'b0000000, 3'b111}: aluOp = cpuPkg::aluAnd;
          {7'b0000000, 3'b110}: aluOp = cpuPkg::aluOr;
          {7'b0000000, 3'b100}: aluOp = cpuPkg::aluXor;
          {7'b0000000, 3'b010}: aluOp = cpuPkg::aluSlt;
          default:              regWrite = 1'b0;
        endcase
      end
      cpuPkg::opImm: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        case (funct3)
          3'b000:  aluOp = cpuPkg::aluAdd;
          3'b111:  aluOp = cpuPkg::aluAnd;
          3'b110:  aluOp = cpuPkg::aluOr;
          3'b100:  aluOp = cpuPkg::aluXor;
          default: regWrite = 1'b0;
        endcase
      end
      cpuPkg::opLoad: begin
        if (funct3 == 3'b010) begin
          aluSrc   = 1'b1;
          memRead  = 1'b1;
          memToReg = 1'b1;
          regWrite = 1'b1;
        end
      end
      cpuPkg::opStore: begin
        if (funct3 == 3'b010) begin
          aluSrc   = 1'b1;
          memWrite = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // Load in execute feeding the instruction in decode
  assign stall = instrValid && idEx.memRead && idEx.rdIndex != '0 &&
                 (idEx.rdIndex == rs1Index || idEx.rdIndex == rs2Index);

  always_comb begin
    idExNext.rs1Data  = rs1Data;
    idExNext.rs2Data  = rs2Data;
    idExNext.rs1Index = rs1Index;
    idExNext.rs2Index = rs2Index;
    idExNext.rdIndex  = instr[11:7];
    idExNext.imm      = (instr[6:0] == cpuPkg::opStore) ? immS : immI;
    idExNext.aluOp    = aluOp;
    idExNext.aluSrc   = aluSrc;
    idExNext.memRead  = memRead;
    idExNext.memWrite = memWrite;
    idExNext.memToReg = memToReg;
    idExNext.regWrite = regWrite;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idEx <= '0;
    end else if (stall || !instrValid) begin
      idEx <= '0;
    end else begin
      idEx <= idExNext;
    end
  end

endmodule

//--- logic/forwardingUnit.sv
`timescale 1ns/1ps

module forwardingUnit (
  input  logic [cpuPkg::regIndexW-1:0]  readIndex,
  input  logic [cpuPkg::regIndexW-1:0]  memWriteIndex,
  input  logic [cpuPkg::regIndexW-1:0]  wbWriteIndex,
  input  logic                          memRegWrite,
  input  logic                          wbRegWrite,
  output cpuPkg::fwdSelT                select
);

  // Youngest producer wins, x0 is never forwarded
  always_comb begin
    select = cpuPkg::fwdNone;
    if (readIndex != '0) begin
      if (memRegWrite && memWriteIndex == readIndex) begin
        select = cpuPkg::fwdMem;
      end else if (wbRegWrite && wbWriteIndex == readIndex) begin
        select = cpuPkg::fwdWb;
      end
    end
  end

endmodule

//--- logic/executeAlu.sv
`timescale 1ns/1ps

module executeAlu (
  input  logic                     clk,
  input  logic                     arstN,
  input  cpuPkg::idExT             idEx,
  input  cpuPkg::fwdSelT           lhsSelect,
  input  cpuPkg::fwdSelT           rhsSelect,
  input  logic [cpuPkg::xlen-1:0]  memForward,
  input  logic [cpuPkg::xlen-1:0]  wbForward,
  output cpuPkg::exMemT            exMem
);

  logic [cpuPkg::xlen-1:0] lhs;
  logic [cpuPkg::xlen-1:0] rhsReg;
  logic [cpuPkg::xlen-1:0] rhs;
  logic [cpuPkg::xlen-1:0] result;

  function automatic logic [cpuPkg::xlen-1:0] pickOperand(
    input cpuPkg::fwdSelT          sel,
    input logic [cpuPkg::xlen-1:0] pipeValue,
    input logic [cpuPkg::xlen-1:0] memValue,
    input logic [cpuPkg::xlen-1:0] wbValue
  );
    case (sel)
      cpuPkg::fwdMem: return memValue;
      cpuPkg::fwdWb:  return wbValue;
      default:        return pipeValue;
    endcase
  endfunction

  assign lhs    = pickOperand(lhsSelect, idEx.rs1Data, memForward, wbForward);
  assign rhsReg = pickOperand(rhsSelect, idEx.rs2Data, memForward, wbForward);
  // Immediate replaces the register only after forwarding
  assign rhs    = idEx.aluSrc ? idEx.imm : rhsReg;

  always_comb begin
    case (idEx.aluOp)
      cpuPkg::aluSub: result = lhs - rhs;
      cpuPkg::aluAnd: result = lhs & rhs;
      cpuPkg::aluOr:  result = lhs | rhs;
      cpuPkg::aluXor: result = lhs ^ rhs;
      cpuPkg::aluSlt: result = {{(cpuPkg::xlen-1){1'b0}}, $signed(lhs) < $signed(rhs)};
      default:        result = lhs + rhs;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMem <= '0;
    end else begin
      exMem.aluResult <= result;
      exMem.storeData <= rhsReg;
      exMem.rdIndex   <= idEx.rdIndex;
      exMem.memRead   <= idEx.memRead;
      exMem.memWrite  <= idEx.memWrite;
      exMem.memToReg  <= idEx.memToReg;
      exMem.regWrite  <= idEx.regWrite;
    end
  end

endmodule

//--- logic/dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
  input  logic           clk,
  input  logic           arstN,
  input  cpuPkg::exMemT  exMem,
  output cpuPkg::memWbT  memWb
);

  logic [cpuPkg::xlen-1:0]                mem [cpuPkg::dmemDepth];
  logic [$clog2(cpuPkg::dmemDepth)-1:0]   wordAddr;
  logic [cpuPkg::xlen-1:0]                readData;

  // Word address from bits 7 to 2
  assign wordAddr = exMem.aluResult[$clog2(cpuPkg::dmemDepth)+1:2];
  assign readData = exMem.memRead ? mem[wordAddr] : '0;

  always_ff @(posedge clk) begin
    if (exMem.memWrite) begin
      mem[wordAddr] <= exMem.storeData;
    end
  end

  // Memory/writeback barrier
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memWb <= '0;
    end else begin
      memWb.loadData <= readData;
      memWb.execData <= exMem.aluResult;
      memWb.rdIndex  <= exMem.rdIndex;
      memWb.memToReg <= exMem.memToReg;
      memWb.regWrite <= exMem.regWrite;
    end
  end

endmodule

//--- logic/cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic                                  clk,
  input  logic                                  arstN,
  input  logic                                  run,
  input  logic                                  progWrite,
  input  logic [$clog2(cpuPkg::imemDepth)-1:0]  progAddr,
  input  logic [cpuPkg::xlen-1:0]               progData,
  output logic                                  retireValid,
  output logic [cpuPkg::regIndexW-1:0]          retireIndex,
  output logic [cpuPkg::xlen-1:0]               retireData
);

  logic [cpuPkg::xlen-1:0]      instr;
  logic                         instrValid;
  logic [cpuPkg::regIndexW-1:0] rs1Index;
  logic [cpuPkg::regIndexW-1:0] rs2Index;
  logic [cpuPkg::xlen-1:0]      rs1Data;
  logic [cpuPkg::xlen-1:0]      rs2Data;
  logic                         stall;
  cpuPkg::idExT                 idEx;
  cpuPkg::exMemT                exMem;
  cpuPkg::memWbT                memWb;
  cpuPkg::fwdSelT               lhsSelect;
  cpuPkg::fwdSelT               rhsSelect;
  logic [cpuPkg::xlen-1:0]      wbData;

  instructionFetch fetchStage (
    .clk        (clk),
    .arstN      (arstN),
    .run        (run),
    .stall      (stall),
    .progWrite  (progWrite),
    .progAddr   (progAddr),
    .progData   (progData),
    .instr      (instr),
    .instrValid (instrValid)
  );

  registerFile regFile (
    .clk         (clk),
    .arstN       (arstN),
    .rs1Index    (rs1Index),
    .rs2Index    (rs2Index),
    .writeIndex  (memWb.rdIndex),
    .writeData   (wbData),
    .writeEnable (memWb.regWrite),
    .rs1Data     (rs1Data),
    .rs2Data     (rs2Data)
  );

  decodeControl decodeStage (
    .clk        (clk),
    .arstN      (arstN),
    .instr      (instr),
    .instrValid (instrValid),
    .rs1Index   (rs1Index),
    .rs2Index   (rs2Index),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data),
    .stall      (stall),
    .idEx       (idEx)
  );

  forwardingUnit lhsForwarding (
    .readIndex     (idEx.rs1Index),
    .memWriteIndex (exMem.rdIndex),
    .wbWriteIndex  (memWb.rdIndex),
    .memRegWrite   (exMem.regWrite),
    .wbRegWrite    (memWb.regWrite),
    .select        (lhsSelect)
  );

  forwardingUnit rhsForwarding (
    .readIndex     (idEx.rs2Index),
    .memWriteIndex (exMem.rdIndex),
    .wbWriteIndex  (memWb.rdIndex),
    .memRegWrite   (exMem.regWrite),
    .wbRegWrite    (memWb.regWrite),
    .select        (rhsSelect)
  );

  executeAlu executeStage (
    .clk        (clk),
    .arstN      (arstN),
    .idEx       (idEx),
    .lhsSelect  (lhsSelect),
    .rhsSelect  (rhsSelect),
    .memForward (exMem.aluResult),
    .wbForward  (wbData),
    .exMem      (exMem)
  );

  dataMemory memoryStage (
    .clk   (clk),
    .arstN (arstN),
    .exMem (exMem),
    .memWb (memWb)
  );

  // Writeback mux
  assign wbData = memWb.memToReg ? memWb.loadData : memWb.execData;

  // Trace shows only writes that land in a real register
  assign retireValid = memWb.regWrite && memWb.rdIndex != '0;
  assign retireIndex = memWb.rdIndex;
  assign retireData  = wbData;

endmodule

//--- verification/pipeline_checker.sv
`timescale 1ns/1ps

module pipelineChecker (
  input logic                          clk,
  input logic                          arstN,
  input logic                          run,
  input logic                          stall,
  input logic                          retireValid,
  input logic [cpuPkg::regIndexW-1:0]  retireIndex
);

  logic runSeen;
  int   idleRetireErrors = 0;
  int   zeroIndexErrors = 0;
  int   doubleStallErrors = 0;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      runSeen <= 1'b0;
    end else if (run) begin
      runSeen <= 1'b1;
    end
  end

  // Nothing may retire before the core is started
  assert property (@(posedge clk) disable iff (!arstN) !runSeen |-> !retireValid)
    else begin
      $error("retirement seen before run was raised");
      idleRetireErrors++;
    end

  assert property (@(posedge clk) disable iff (!arstN) retireValid |-> retireIndex != '0)
    else begin
      $error("retirement trace shows a write to x0");
      zeroIndexErrors++;
    end

  // A bubble follows every stall, so no back-to-back stalls
  assert property (@(posedge clk) disable iff (!arstN) stall |=> !stall)
    else begin
      $error("stall held for two consecutive cycles");
      doubleStallErrors++;
    end

endmodule

bind cpu pipelineChecker pipeChecks (
  .clk         (clk),
  .arstN       (arstN),
  .run         (run),
  .stall       (stall),
  .retireValid (retireValid),
  .retireIndex (retireIndex)
);

//--- verification/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

  localparam int randomLen = 48;
  localparam int progLen = randomLen + 4;
  localparam int drainCycles = 10;
  localparam int timeoutNs = 4 * (progLen + progLen + drainCycles) * 20;

  typedef struct packed {
    logic [cpuPkg::regIndexW-1:0] index;
    logic [cpuPkg::xlen-1:0]      data;
  } retireT;

  logic                         clk;
  logic                         arstN;
  logic                         run;
  logic                         progWrite;
  logic [5:0]                   progAddr;
  logic [cpuPkg::xlen-1:0]      progData;
  logic                         retireValid;
  logic [cpuPkg::regIndexW-1:0] retireIndex;
  logic [cpuPkg::xlen-1:0]      retireData;

  logic [31:0] progWords [progLen];
  logic [31:0] modelRegs [32];
  logic [31:0] modelMem [64];
  retireT      expected [$];

  cpu i_dut (
    .clk         (clk),
    .arstN       (arstN),
    .run         (run),
    .progWrite   (progWrite),
    .progAddr    (progAddr),
    .progData    (progData),
    .retireValid (retireValid),
    .retireIndex (retireIndex),
    .retireData  (retireData)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  function automatic logic [31:0] encodeS(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // Small register window keeps forwarding and load-use cases frequent
  task automatic buildProgram();
    int          kind;
    int          slot;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [15:0] stored;
    stored = '0;
    for (int i = 0; i < randomLen; i++) begin
      kind = $urandom_range(0, 15);
      rd   = 5'($urandom_range(1, 7));
      rs1  = 5'($urandom_range(0, 7));
      rs2  = 5'($urandom_range(0, 7));
      imm  = 12'($urandom);
      if (kind >= 10 && kind <= 12 && stored == '0) begin
        kind = 13;
      end
      case (kind)
        0:  progWords[i] = encodeR(7'b0000000, rs2, rs1, 3'b000, rd);
        1:  progWords[i] = encodeR(7'b0100000, rs2, rs1, 3'b000, rd);
        2:  progWords[i] = encodeR(7'b0000000, rs2, rs1, 3'b111, rd);
        3:  progWords[i] = encodeR(7'b0000000, rs2, rs1, 3'b110, rd);
        4:  progWords[i] = encodeR(7'b0000000, rs2, rs1, 3'b100, rd);
        5:  progWords[i] = encodeR(7'b0000000, rs2, rs1, 3'b010, rd);
        6:  progWords[i] = encodeI(imm, rs1, 3'b000, rd, 7'b0010011);
        7:  progWords[i] = encodeI(imm, rs1, 3'b111, rd, 7'b0010011);
        8:  progWords[i] = encodeI(imm, rs1, 3'b110, rd, 7'b0010011);
        9:  progWords[i] = encodeI(imm, rs1, 3'b100, rd, 7'b0010011);
        10, 11, 12: begin
          // Only words that a store has already written
          do begin
            slot = $urandom_range(0, 15);
          end while (!stored[slot]);
          progWords[i] = encodeI(12'(slot * 4), 5'd0, 3'b010, rd, 7'b0000011);
        end
        default: begin
          slot = $urandom_range(0, 15);
          stored[slot] = 1'b1;
          progWords[i] = encodeS(12'(slot * 4), rs2);
        end
      endcase
    end
    for (int i = randomLen; i < progLen; i++) begin
      progWords[i] = 32'h0000_0013;
    end
  endtask

  // Sequential RV32I semantics, one instruction at a time
  task automatic modelStep(input logic [31:0] word);
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] res;
    logic        writes;
    rd     = word[11:7];
    a      = modelRegs[word[19:15]];
    b      = modelRegs[word[24:20]];
    immI   = {{20{word[31]}}, word[31:20]};
    immS   = {{20{word[31]}}, word[31:25], word[11:7]};
    res    = '0;
    writes = 1'b1;
    case (word[6:0])
      cpuPkg::opReg: begin
        case ({word[31:25], word[14:12]})
          10'b0000000_000: res = a + b;
          10'b0100000_000: res = a - b;
          10'b0000000_111: res = a & b;
          10'b0000000_110: res = a | b;
          10'b0000000_100: res = a ^ b;
          10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default:         writes = 1'b0;
        endcase
      end
      cpuPkg::opImm: begin
        case (word[14:12])
          3'b000:  res = a + immI;
          3'b111:  res = a & immI;
          3'b110:  res = a | immI;
          3'b100:  res = a ^ immI;
          default: writes = 1'b0;
        endcase
      end
      cpuPkg::opLoad: begin
        res = modelMem[(a + immI) >> 2 & 32'd63];
      end
      cpuPkg::opStore: begin
        writes = 1'b0;
        modelMem[(a + immS) >> 2 & 32'd63] = b;
      end
      default: writes = 1'b0;
    endcase
    if (writes && rd != 5'd0) begin
      modelRegs[rd] = res;
      expected.push_back('{index: rd, data: res});
    end
  endtask

  task automatic checkRetirement();
    retireT head;
    assert (expected.size() != 0) else begin
      $display("Extra retirement of x%0d at %0t after all expected writes", retireIndex, $time);
      $display("test failed");
      $fatal(1, "unexpected retirement");
    end
    head = expected.pop_front();
    assert (retireIndex == head.index && retireData == head.data) else begin
      $display("FAIL %0t: retired x%0d = %h, expected x%0d = %h",
               $time, retireIndex, retireData, head.index, head.data);
      $display("test failed");
      $fatal(1, "retirement mismatch");
    end
  endtask

  always @(negedge clk) begin
    if (arstN && retireValid) begin
      checkRetirement();
    end
  end

  initial begin
    #(timeoutNs);
    $display("Timeout: not all writes retired, %0d still pending", expected.size());
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(57607));
    arstN     <= 1'b0;
    run       <= 1'b0;
    progWrite <= 1'b0;
    progAddr  <= '0;
    progData  <= '0;
    buildProgram();
    for (int i = 0; i < 32; i++) begin
      modelRegs[i] = '0;
    end
    for (int i = 0; i < progLen; i++) begin
      modelStep(progWords[i]);
    end
    repeat (16) @(posedge clk);
    arstN <= 1'b1;
    for (int i = 0; i < progLen; i++) begin
      @(posedge clk);
      progWrite <= 1'b1;
      progAddr  <= 6'(i);
      progData  <= progWords[i];
    end
    @(posedge clk);
    progWrite <= 1'b0;
    run       <= 1'b1;
    while (expected.size() != 0) begin
      @(negedge clk);
    end
    // Any late write during the drain shows up as an extra retirement
    repeat (drainCycles) @(negedge clk);
    if (i_dut.pipeChecks.idleRetireErrors + i_dut.pipeChecks.zeroIndexErrors +
        i_dut.pipeChecks.doubleStallErrors == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("A pipeline control assertion fired during the run");
      $display("test failed");
      $fatal(1, "pipeline assertion");
    end
  end

endmodule

//--- cpu.f
logic/cpuPkg.sv
logic/instructionFetch.sv
logic/registerFile.sv
logic/decodeControl.sv
logic/forwardingUnit.sv
logic/executeAlu.sv
logic/dataMemory.sv
logic/cpu.sv
verification/pipeline_checker.sv
verification/cpuTb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := cpuTb
FILELIST := cpu.f
LOG      := sim.log

.PHONY: sim clean

# The run passes only when the log holds the pass line
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
